// File: build.f
+incdir+tb
hw/rx_dsp_pkg.sv
hw/prbs_pkg.sv
hw/adc_unfold.sv
hw/data_slicer.sv
hw/prbs_gen.sv
hw/prbs_checker.sv
hw/rx_digital_core.sv
tb/tb_rx_digital_core.sv

// File: Makefile
# Verilator build and run of the receive BER testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_digital_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# pass only when the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/rx_tb_tasks.svh
`ifndef RX_TB_TASKS_SVH
`define RX_TB_TASKS_SVH

// model of each pipeline register, updated once per rising edge
int                   m_unf [NTI];
logic [NTI-1:0]       m_adc_q;
logic [NTI-1:0]       m_bist_q;
logic [NTI-1:0]       m_word_q;
prbs_pkg::chk_mode_e  m_mode_q;
prbs_pkg::prbs_hist_t m_hist;
logic                 m_valid;
prbs_pkg::prbs_hist_t m_gen;
prbs_pkg::count_t     m_err;
prbs_pkg::count_t     m_total;

// plus magnitude for sign 1, minus magnitude for sign 0, then minus offset
function automatic int unfold_value(input rx_dsp_pkg::adc_code_t code, input logic sign,
                                    input rx_dsp_pkg::pfd_offset_t offset);
    int mag;
    mag = int'(code);
    return (sign ? mag : -mag) - int'(offset);
endfunction

// slicer decision for the sample currently on the inputs
function automatic logic [NTI-1:0] slice_driven();
    logic [NTI-1:0] w;
    for (int k = 0; k < NTI; k++) begin
        w[k] = unfold_value(adcout[k], adcout_sign[k], pfd_offset) > int'(thresh);
    end
    return w;
endfunction

// serial PRBS7, hist bit 0 is the oldest bit
task automatic advance_prbs(inout prbs_pkg::prbs_hist_t hist, output logic [NTI-1:0] word);
    logic nb;
    for (int n = 0; n < NTI; n++) begin
        nb = hist[prbs_pkg::PRBS_ORDER - prbs_pkg::PRBS_TAP_A]
           ^ hist[prbs_pkg::PRBS_ORDER - prbs_pkg::PRBS_TAP_B];
        hist = {nb, hist[prbs_pkg::PRBS_ORDER-1:1]};
        word[n] = nb;
    end
endtask

// bits of the word that break the recurrence, history in front
function automatic int count_word_errors(input prbs_pkg::prbs_hist_t hist,
                                         input logic [NTI-1:0] word);
    logic [NTI+prbs_pkg::PRBS_ORDER-1:0] s;
    int errs;
    s = {word, hist};
    errs = 0;
    for (int n = prbs_pkg::PRBS_ORDER; n < NTI + prbs_pkg::PRBS_ORDER; n++) begin
        if (s[n] != (s[n-prbs_pkg::PRBS_TAP_A] ^ s[n-prbs_pkg::PRBS_TAP_B])) begin
            errs++;
        end
    end
    return errs;
endfunction

task automatic model_reset();
    m_unf = '{default: 0};
    m_adc_q = '0;
    m_bist_q = '0;
    m_word_q = '0;
    m_mode_q = prbs_pkg::CHK_HOLD;
    m_hist = '0;
    m_valid = 1'b0;
    m_gen = '1;
    m_err = '0;
    m_total = '0;
endtask

// stages updated from the last one backwards so each sees old values
task automatic model_edge();
    logic [NTI-1:0] gen_word;
    case (m_mode_q)
        prbs_pkg::CHK_CLEAR: begin
            m_err = '0;
            m_total = '0;
            m_valid = 1'b0;
        end
        prbs_pkg::CHK_RUN: begin
            if (m_valid) begin
                m_err = m_err + prbs_pkg::count_t'(count_word_errors(m_hist, m_word_q));
                m_total = m_total + prbs_pkg::count_t'(NTI);
            end else begin
                m_valid = 1'b1;
            end
        end
        default: ;
    endcase
    m_hist = m_word_q[NTI-1 -: prbs_pkg::PRBS_ORDER];
    m_word_q = (sel_src == prbs_pkg::SRC_BIST) ? m_bist_q : m_adc_q;
    m_mode_q = chk_mode;
    for (int k = 0; k < NTI; k++) begin
        m_adc_q[k] = m_unf[k] > int'(thresh);
        m_unf[k] = unfold_value(adcout[k], adcout_sign[k], pfd_offset);
    end
    advance_prbs(m_gen, gen_word);
    m_bist_q = gen_word ^ {{(NTI-1){1'b0}}, inj_err};
endtask

// one clock, model follows the edge, inputs may change 1 ns later
task automatic tick();
    @(posedge clk_adc);
    if (rst) begin
        model_reset();
    end else begin
        model_edge();
    end
    #1;
endtask

task automatic drive_random_adc();
    for (int k = 0; k < NTI; k++) begin
        adcout[k] = rx_dsp_pkg::adc_code_t'($random(seed));
    end
    adcout_sign = NTI'($random(seed));
endtask

task automatic run_cycles(input int n);
    for (int i = 0; i < n; i++) begin
        drive_random_adc();
        tick();
    end
endtask

// last counted word needs 4 edges to reach the counters
task automatic settle_in_hold();
    chk_mode = prbs_pkg::CHK_HOLD;
    for (int i = 0; i < 4; i++) begin
        tick();
    end
endtask

task automatic wait_counts_zero(input int max_cycles);
    int waited;
    for (waited = 0; waited < max_cycles; waited++) begin
        if (err_count == '0 && total_count == '0) begin
            break;
        end
        tick();
    end
    if (err_count != '0 || total_count != '0) begin
        $display("counters did not return to zero within %0d cycles of clear", max_cycles);
        stop_on_error();
    end
endtask

task automatic check_count(input string name, input prbs_pkg::count_t got,
                           input prbs_pkg::count_t exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_bits(input string name, input logic [NTI-1:0] got,
                          input logic [NTI-1:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_model_counts();
    check_count("err_count_o", err_count, m_err);
    check_count("total_count_o", total_count, m_total);
endtask

task automatic test_after_reset();
    $display("test: after reset");
    settle_in_hold();
    check_count("err_count_o", err_count, '0);
    check_count("total_count_o", total_count, '0);
    check_model_counts();
endtask

task automatic test_bist_clean();
    $display("test: bist without errors");
    sel_src = prbs_pkg::SRC_BIST;
    chk_mode = prbs_pkg::CHK_CLEAR;
    run_cycles(2);
    chk_mode = prbs_pkg::CHK_RUN;
    run_cycles(200);
    settle_in_hold();
    check_count("err_count_o", err_count, '0);
    check_count("total_count_o", total_count, prbs_pkg::count_t'(NTI * 199));
    check_model_counts();
endtask

task automatic test_bist_inject();
    int pulses;
    $display("test: bist with injected errors");
    pulses = 0;
    sel_src = prbs_pkg::SRC_BIST;
    chk_mode = prbs_pkg::CHK_CLEAR;
    run_cycles(2);
    chk_mode = prbs_pkg::CHK_RUN;
    for (int i = 0; i < 100; i++) begin
        // pulses 15 cycles apart, far from the run edges
        if (i % 15 == 5 && pulses < 5) begin
            inj_err = 1'b1;
            pulses++;
        end else begin
            inj_err = 1'b0;
        end
        run_cycles(1);
    end
    inj_err = 1'b0;
    settle_in_hold();
    check_count("err_count_o", err_count, prbs_pkg::count_t'(15));
    check_count("total_count_o", total_count, prbs_pkg::count_t'(NTI * 99));
    check_model_counts();
endtask

task automatic test_adc_prbs();
    prbs_pkg::prbs_hist_t src_hist;
    logic [NTI-1:0] word;
    int flips;
    $display("test: adc path with prbs data");
    pfd_offset = '0;
    thresh = '0;
    sel_src = prbs_pkg::SRC_ADC;
    chk_mode = prbs_pkg::CHK_CLEAR;
    src_hist = '1;
    flips = 0;
    for (int w = 0; w < 120; w++) begin
        advance_prbs(src_hist, word);
        if (w == 20 || w == 50 || w == 85) begin
            word[(w * 3) % NTI] = ~word[(w * 3) % NTI];
            flips++;
        end
        for (int k = 0; k < NTI; k++) begin
            adcout_sign[k] = word[k];
            adcout[k] = word[k] ? rx_dsp_pkg::adc_code_t'(1 + ($unsigned($random(seed)) % 255))
                                : rx_dsp_pkg::adc_code_t'($random(seed));
        end
        check_bits("adc slice model", slice_driven(), word);
        if (w == 3) begin
            chk_mode = prbs_pkg::CHK_RUN;
        end
        tick();
    end
    settle_in_hold();
    check_count("err_count_o", err_count, prbs_pkg::count_t'(3 * flips));
    check_model_counts();
endtask

task automatic test_offset_thresh();
    $display("test: offset and threshold");
    pfd_offset = rx_dsp_pkg::pfd_offset_t'($random(seed));
    thresh = rx_dsp_pkg::unfolded_t'($random(seed) % 64);
    sel_src = prbs_pkg::SRC_ADC;
    chk_mode = prbs_pkg::CHK_CLEAR;
    run_cycles(3);
    chk_mode = prbs_pkg::CHK_RUN;
    run_cycles(100);
    settle_in_hold();
    check_count("total_count_o", total_count, prbs_pkg::count_t'(NTI * 99));
    check_model_counts();
endtask

task automatic test_clear_hold();
    prbs_pkg::count_t held_err;
    prbs_pkg::count_t held_total;
    $display("test: clear and hold");
    sel_src = prbs_pkg::SRC_BIST;
    chk_mode = prbs_pkg::CHK_CLEAR;
    run_cycles(2);
    chk_mode = prbs_pkg::CHK_RUN;
    inj_err = 1'b1;
    run_cycles(1);
    inj_err = 1'b0;
    run_cycles(40);
    settle_in_hold();
    held_err = err_count;
    held_total = total_count;
    check_count("err_count_o", held_err, prbs_pkg::count_t'(3));
    check_count("total_count_o", held_total, prbs_pkg::count_t'(NTI * 40));
    check_model_counts();
    // traffic and errors keep coming while held
    for (int i = 0; i < 30; i++) begin
        inj_err = (i % 6 == 0);
        run_cycles(1);
        check_count("err_count_o", err_count, held_err);
        check_count("total_count_o", total_count, held_total);
    end
    inj_err = 1'b0;
    chk_mode = prbs_pkg::CHK_CLEAR;
    wait_counts_zero(8);
    settle_in_hold();
    check_count("err_count_o", err_count, '0);
    check_count("total_count_o", total_count, '0);
    check_model_counts();
endtask

`endif

// File: tb/tb_rx_digital_core.sv
`timescale 1ns/100ps

module tb_rx_digital_core;

    localparam int NTI = rx_dsp_pkg::NTI_DEFAULT;

    logic                    clk_adc = 1'b0;
    logic                    rst;
    rx_dsp_pkg::adc_code_t   adcout [NTI-1:0];
    logic [NTI-1:0]          adcout_sign;
    rx_dsp_pkg::pfd_offset_t pfd_offset;
    rx_dsp_pkg::unfolded_t   thresh;
    prbs_pkg::prbs_src_e     sel_src;
    prbs_pkg::chk_mode_e     chk_mode;
    logic                    inj_err;
    prbs_pkg::count_t        err_count;
    prbs_pkg::count_t        total_count;

    integer seed;

    // 10 ns clock
    always #5 clk_adc = ~clk_adc;

    rx_digital_core #(
        .n_ti(NTI)
    ) DUT (
        .clk_adc      (clk_adc),
        .rst_i        (rst),
        .adcout_i     (adcout),
        .adcout_sign_i(adcout_sign),
        .pfd_offset_i (pfd_offset),
        .thresh_i     (thresh),
        .sel_src_i    (sel_src),
        .chk_mode_i   (chk_mode),
        .inj_err_i    (inj_err),
        .err_count_o  (err_count),
        .total_count_o(total_count)
    );

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    `include "rx_tb_tasks.svh"

    initial begin
        seed = 32'ha8aeed19;
        rst = 1'b1;
        for (int k = 0; k < NTI; k++) begin
            adcout[k] = '0;
        end
        adcout_sign = '0;
        pfd_offset = '0;
        thresh = '0;
        sel_src = prbs_pkg::SRC_BIST;
        chk_mode = prbs_pkg::CHK_HOLD;
        inj_err = 1'b0;
        model_reset();

        // reset held for 10 cycles
        for (int i = 0; i < 10; i++) begin
            tick();
        end
        rst = 1'b0;

        test_after_reset();
        test_bist_clean();
        test_bist_inject();
        test_adc_prbs();
        test_offset_thresh();
        test_clear_hold();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: hw/rx_digital_core.sv
`timescale 1ns/100ps
`default_nettype none

module rx_digital_core #(
    // must be at least the PRBS order
    parameter int n_ti = rx_dsp_pkg::NTI_DEFAULT
) (
    input wire logic                   clk_adc,
    input wire logic                   rst_i,
    input rx_dsp_pkg::adc_code_t       adcout_i [n_ti-1:0],
    input wire logic [n_ti-1:0]        adcout_sign_i,
    input rx_dsp_pkg::pfd_offset_t     pfd_offset_i,
    input rx_dsp_pkg::unfolded_t       thresh_i,
    input prbs_pkg::prbs_src_e         sel_src_i,
    input prbs_pkg::chk_mode_e         chk_mode_i,
    input wire logic                   inj_err_i,
    output prbs_pkg::count_t           err_count_o,
    output prbs_pkg::count_t           total_count_o
);

    rx_dsp_pkg::unfolded_t   adcout_unfolded [n_ti-1:0];
    logic [n_ti-1:0]         bits_adc;
    logic [n_ti-1:0]         bits_bist;

    // sign/magnitude to signed, minus PFD offset
    adc_unfold #(
        .n_ti(n_ti)
    ) adc_unfold_i (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .adcout_i     (adcout_i),
        .adcout_sign_i(adcout_sign_i),
        .pfd_offset_i (pfd_offset_i),
        .unfolded_o   (adcout_unfolded)
    );

    // digital comparator on the unfolded codes
    data_slicer #(
        .n_ti(n_ti)
    ) data_slicer_i (
        .clk_adc   (clk_adc),
        .rst_i     (rst_i),
        .unfolded_i(adcout_unfolded),
        .thresh_i  (thresh_i),
        .bits_o    (bits_adc)
    );

    // BIST source
    prbs_gen #(
        .n_ti(n_ti)
    ) prbs_gen_i (
        .clk_adc  (clk_adc),
        .rst_i    (rst_i),
        .inj_err_i(inj_err_i),
        .bits_o   (bits_bist)
    );

    // bit error counting on ADC or BIST data
    prbs_checker #(
        .n_ti(n_ti)
    ) prbs_checker_i (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .adc_bits_i   (bits_adc),
        .bist_bits_i  (bits_bist),
        .sel_src_i    (sel_src_i),
        .chk_mode_i   (chk_mode_i),
        .err_count_o  (err_count_o),
        .total_count_o(total_count_o)
    );

endmodule

`default_nettype wire

// File: hw/prbs_checker.sv
`timescale 1ns/100ps
`default_nettype none

module prbs_checker #(
    parameter int n_ti = rx_dsp_pkg::NTI_DEFAULT
) (
    input wire logic              clk_adc,
    input wire logic              rst_i,
    input wire logic [n_ti-1:0]   adc_bits_i,
    input wire logic [n_ti-1:0]   bist_bits_i,
    input prbs_pkg::prbs_src_e    sel_src_i,
    input prbs_pkg::chk_mode_e    chk_mode_i,
    output prbs_pkg::count_t      err_count_o,
    output prbs_pkg::count_t      total_count_o
);

    localparam int ORDER = prbs_pkg::PRBS_ORDER;
    localparam int POP_W = $clog2(n_ti + 1);

    // select stage
    logic [n_ti-1:0]         word_q;
    prbs_pkg::chk_mode_e     mode_q;

    // check stage
    prbs_pkg::prbs_hist_t    hist_q;
    logic                    hist_valid_q;
    logic [n_ti+ORDER-1:0]   stream;
    logic [n_ti-1:0]         mismatch;
    logic [POP_W-1:0]        pop;

    // the mode travels with the word it was sampled with
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            word_q <= '0;
            mode_q <= prbs_pkg::CHK_HOLD;
        end else begin
            word_q <= (sel_src_i == prbs_pkg::SRC_BIST) ? bist_bits_i : adc_bits_i;
            mode_q <= chk_mode_i;
        end
    end

    // previous bits followed by the current word, oldest at bit 0
    assign stream = {word_q, hist_q};

    always_comb begin
        for (int n = 0; n < n_ti; n++) begin
            mismatch[n] = stream[n+ORDER]
                        ^ stream[n+ORDER-prbs_pkg::PRBS_TAP_A]
                        ^ stream[n+ORDER-prbs_pkg::PRBS_TAP_B];
        end
    end

    // population count of the mismatch word
    always_comb begin
        pop = '0;
        for (int n = 0; n < n_ti; n++) begin
            pop = pop + POP_W'(mismatch[n]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist_q        <= '0;
            hist_valid_q  <= 1'b0;
            err_count_o   <= '0;
            total_count_o <= '0;
        end else begin
            // history always follows the stream
            hist_q <= word_q[n_ti-1 -: ORDER];

            case (mode_q)
                prbs_pkg::CHK_CLEAR: begin
                    hist_valid_q  <= 1'b0;
                    err_count_o   <= '0;
                    total_count_o <= '0;
                end
                prbs_pkg::CHK_RUN: begin
                    if (hist_valid_q) begin
                        err_count_o   <= err_count_o + prbs_pkg::count_t'(pop);
                        total_count_o <= total_count_o + prbs_pkg::count_t'(n_ti);
                    end else begin
                        // first word only primes the history
                        hist_valid_q <= 1'b1;
                    end
                end
                default: begin
                    // hold, counters frozen
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/prbs_gen.sv
`timescale 1ns/100ps
`default_nettype none

module prbs_gen #(
    parameter int n_ti = rx_dsp_pkg::NTI_DEFAULT
) (
    input wire logic          clk_adc,
    input wire logic          rst_i,
    input wire logic          inj_err_i,
    output logic [n_ti-1:0]   bits_o
);

    localparam int ORDER = prbs_pkg::PRBS_ORDER;
    localparam int EXT_W = n_ti + ORDER;

    // generator history, bit ORDER-1 is the most recent bit
    prbs_pkg::prbs_hist_t state;

    // history in the low bits, the new word unrolled above it
    logic [EXT_W-1:0] ext;

    logic [n_ti-1:0] word;
    logic [n_ti-1:0] err_mask;

    always_comb begin
        ext[ORDER-1:0] = state;
        for (int n = ORDER; n < EXT_W; n++) begin
            ext[n] = ext[n-prbs_pkg::PRBS_TAP_A] ^ ext[n-prbs_pkg::PRBS_TAP_B];
        end
    end

    assign word = ext[EXT_W-1:ORDER];

    // only the earliest bit of the word is hit
    assign err_mask = {{(n_ti-1){1'b0}}, inj_err_i};

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            state  <= '1;
            bits_o <= '0;
        end else begin
            // state follows the clean sequence
            // so an injected error stays a single flipped bit
            state  <= ext[EXT_W-1 -: ORDER];
            bits_o <= word ^ err_mask;
        end
    end

endmodule

`default_nettype wire

// File: hw/data_slicer.sv
`timescale 1ns/100ps
`default_nettype none

module data_slicer #(
    parameter int n_ti = rx_dsp_pkg::NTI_DEFAULT
) (
    input wire logic                   clk_adc,
    input wire logic                   rst_i,
    input rx_dsp_pkg::unfolded_t       unfolded_i [n_ti-1:0],
    input rx_dsp_pkg::unfolded_t       thresh_i,
    output logic [n_ti-1:0]            bits_o
);

    logic [n_ti-1:0] decision;

    // signed compare, a value equal to the threshold slices to zero
    always_comb begin
        for (int k = 0; k < n_ti; k++) begin
            decision[k] = (unfolded_i[k] > thresh_i);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= decision;
        end
    end

endmodule

`default_nettype wire

// File: hw/adc_unfold.sv
`timescale 1ns/100ps
`default_nettype none

module adc_unfold #(
    parameter int n_ti = rx_dsp_pkg::NTI_DEFAULT
) (
    input wire logic                   clk_adc,
    input wire logic                   rst_i,
    input rx_dsp_pkg::adc_code_t       adcout_i [n_ti-1:0],
    input wire logic [n_ti-1:0]        adcout_sign_i,
    input rx_dsp_pkg::pfd_offset_t     pfd_offset_i,
    output rx_dsp_pkg::unfolded_t      unfolded_o [n_ti-1:0]
);

    localparam int GUARD = rx_dsp_pkg::NUNF - rx_dsp_pkg::NADC;

    // offset is shared by all lanes, widen once
    rx_dsp_pkg::unfolded_t offset_ext;

    assign offset_ext = rx_dsp_pkg::unfolded_t'(pfd_offset_i);

    for (genvar k = 0; k < n_ti; k++) begin : g_lane
        rx_dsp_pkg::unfolded_t mag;
        rx_dsp_pkg::unfolded_t signed_mag;
        rx_dsp_pkg::unfolded_t lane_value;

        // zero-extend the magnitude into the signed format
        assign mag = rx_dsp_pkg::unfolded_t'({{GUARD{1'b0}}, adcout_i[k]});

        // sign bit high means a positive sample
        assign signed_mag = adcout_sign_i[k] ? mag : -mag;

        assign lane_value = signed_mag - offset_ext;

        always_ff @(posedge clk_adc) begin
            if (rst_i) begin
                unfolded_o[k] <= '0;
            end else begin
                unfolded_o[k] <= lane_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/prbs_pkg.sv
package prbs_pkg;

    // PRBS7, x^7 + x^6 + 1
    localparam int PRBS_ORDER = 7;

    // bit n of the stream is bit (n-7) xor bit (n-6)
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;

    // width of the error and total accumulators
    localparam int COUNT_W = 64;

    // which word the checker looks at
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } prbs_src_e;

    // checker operating mode
    // the unused code behaves like hold
    typedef enum logic [1:0] {
        CHK_HOLD  = 2'd0,
        CHK_RUN   = 2'd1,
        CHK_CLEAR = 2'd2
    } chk_mode_e;

    typedef logic [COUNT_W-1:0] count_t;

    // last PRBS_ORDER bits of the serial stream, bit 0 oldest
    typedef logic [PRBS_ORDER-1:0] prbs_hist_t;

endpackage

// File: hw/rx_dsp_pkg.sv
package rx_dsp_pkg;

    // magnitude width of one ADC conversion
    localparam int NADC = 8;

    // time-interleaved lanes delivered per clk_adc cycle
    localparam int NTI_DEFAULT = 16;

    // two guard bits on top of the code width
    // so that +/- magnitude minus offset never wraps
    localparam int NUNF = NADC + 2;

    // raw magnitude from one ADC slice, sign travels separately
    typedef logic [NADC-1:0] adc_code_t;

    // external PFD offset, two's complement
    typedef logic signed [NADC-1:0] pfd_offset_t;

    // signed lane value after unfolding
    // the slicer threshold is compared in the same format
    typedef logic signed [NUNF-1:0] unfolded_t;

endpackage
